/* verif/processor_stimulus.txt */
# a b c inv_mask y y_inv, all hex; inv_mask bit 0 flags a, bit 1 b, bit 2 c.
# y = ((a * b) >>> 4) + c on the low halves of a and b, wrapping at 32 bits.
00000010 00000020 00000001 0 00000021 0
00000100 00000030 00001000 0 00001300 0
FFFFFFF0 00000020 00000040 0 00000020 0
FFFFFF00 FFFFFF00 FFFFFFFF 0 00000FFF 0
00000007 00000003 00000000 0 00000001 0
FFFFFFF9 00000003 00000000 0 FFFFFFFE 0
FFFFFFFF 00000001 00000010 0 0000000F 0
FFFFFFEF 00000001 00000002 0 00000000 0
00010000 00000002 00000005 0 00000005 1
00000003 00008000 00000000 0 FFFFE800 1
FFFF8000 00007FFF 00000000 0 FC000800 0
FFFF0005 00000010 00000000 0 00000005 1
00000010 00000020 00000001 1 00000021 1
00000100 00000030 00001000 2 00001300 1
00000007 00000003 00000000 4 00000001 1
00007FFF 00007FFF 7FFFFFFF 0 83FFEFFF 1
FFFF8000 00007FFF 80000000 0 7C000800 1
00000002 00000008 FFFFFFFF 0 00000000 0

/* filelist.f */
+incdir+include
verilog/bus_pkg.sv
verilog/ctrl_pkg.sv
verilog/pu_multiplier.sv
verilog/pu_accum.sv
verilog/pu_io.sv
verilog/control_unit.sv
verilog/processor_top.sv
verif/tb_processor.sv

/* Bender.yml */
package:
  name: microcoded_processor

sources:
  - include_dirs:
      - include
    files:
      - verilog/bus_pkg.sv
      - verilog/ctrl_pkg.sv
      - verilog/pu_multiplier.sv
      - verilog/pu_accum.sv
      - verilog/pu_io.sv
      - verilog/control_unit.sv
      - verilog/processor_top.sv
  - target: test
    files:
      - verif/tb_processor.sv

/* verif/tb_processor.sv */
`default_nettype none

module tb_processor;

    localparam int MAX_WAIT     = 200;  // Cycles per handshake.
    localparam int DRAIN_CYCLES = 20;

    logic               clk;
    logic               rst;
    bus_pkg::bus_word_t in_word;
    logic               in_valid;
    logic               in_ready;
    bus_pkg::bus_word_t out_word;
    logic               out_valid;
    logic               out_ready;

    logic [bus_pkg::DATA_WIDTH-1:0] a_list [$];
    logic [bus_pkg::DATA_WIDTH-1:0] b_list [$];
    logic [bus_pkg::DATA_WIDTH-1:0] c_list [$];
    logic [2:0]                     mask_list [$];  // Invalid flag per word of the triple.
    logic [bus_pkg::DATA_WIDTH-1:0] y_list [$];
    logic                           inv_list [$];
    logic [31:0]                    rand_state;
    int                             errors;
    int                             checks;

    processor_top dut (
        .clk(clk),
        .rst(rst),
        .in_word(in_word),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_word(out_word),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic load_stimulus();
        int fd;
        int n;
        string line;
        logic [31:0] a, b, c, y;
        logic [2:0] mask;
        logic inv;
        fd = $fopen("verif/processor_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h", a, b, c, mask, y, inv);
                if (n == 6) begin
                    a_list.push_back(a);
                    b_list.push_back(b);
                    c_list.push_back(c);
                    mask_list.push_back(mask);
                    y_list.push_back(y);
                    inv_list.push_back(inv);
                end
            end
        end
        $fclose(fd);
        if (y_list.size() == 0) begin
            $display("The stimulus file holds no cases");
            errors++;
        end
    endtask

    // Entered just after a rising edge, returns just after the transfer edge.
    task automatic send_word(input logic [31:0] data, input logic inv, output logic ok);
        int waited;
        in_word = '0;
        in_word.data = data;
        in_word.attr[bus_pkg::ATTR_INVALID] = inv;
        in_valid = 1'b1;
        ok = 1'b0;
        for (waited = 0; waited < MAX_WAIT && !ok; waited++) begin
            @(negedge clk);
            if (in_ready) ok = 1'b1;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic take_result(output bus_pkg::bus_word_t got, output logic ok);
        int waited;
        int hold;
        ok = 1'b0;
        got = '0;
        rand_state = lcg_next(rand_state);
        hold = rand_state[20:16];  // Long enough for the output buffer to fill.
        for (waited = 0; waited < MAX_WAIT && !ok; waited++) begin
            rand_state = lcg_next(rand_state);
            out_ready = (waited >= hold) && rand_state[16];  // Random back-pressure.
            @(negedge clk);
            if (out_valid && out_ready) begin
                ok = 1'b1;
                got = out_word;
            end
            @(posedge clk);
            #1;
        end
        out_ready = 1'b0;
    endtask

    task automatic produce_inputs();
        logic ok;
        for (int i = 0; i < a_list.size(); i++) begin
            send_word(a_list[i], mask_list[i][0], ok);
            if (ok) send_word(b_list[i], mask_list[i][1], ok);
            if (ok) send_word(c_list[i], mask_list[i][2], ok);
            if (!ok) begin
                $display("Timed out waiting for in_ready on case %0d", i);
                errors++;
                break;
            end
        end
    endtask

    task automatic collect_results();
        bus_pkg::bus_word_t got;
        logic ok;
        for (int i = 0; i < y_list.size(); i++) begin
            take_result(got, ok);
            if (!ok) begin
                $display("Timed out waiting for the result of case %0d", i);
                errors++;
                break;
            end
            checks += 2;
            if (got.data !== y_list[i]) begin
                $display("Fail case %0d y: expected %h, actual %h", i, y_list[i], got.data);
                errors++;
            end
            if (got.attr[bus_pkg::ATTR_INVALID] !== inv_list[i]) begin
                $display("Fail case %0d invalid: expected %b, actual %b",
                         i, inv_list[i], got.attr[bus_pkg::ATTR_INVALID]);
                errors++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_word = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        errors = 0;
        checks = 0;
        rand_state = 32'd38061;
        load_stimulus();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checks += 2;
        if (out_valid !== 1'b0) begin
            $display("Fail reset out_valid: expected 0, actual %b", out_valid);
            errors++;
        end
        if (in_ready !== 1'b0) begin
            $display("Fail reset in_ready: expected 0, actual %b", in_ready);
            errors++;
        end
        @(posedge clk);
        #1;
        fork
            produce_inputs();
            collect_results();
        join
        // Nothing more may come out once every case is back.
        out_ready = 1'b1;
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (out_valid) begin
                $display("An extra output word appeared after the last result");
                errors++;
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/processor_top.sv */
`default_nettype none

module processor_top (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::bus_word_t in_word,
    input  logic               in_valid,
    output logic               in_ready,
    output bus_pkg::bus_word_t out_word,
    output logic               out_valid,
    input  logic               out_ready
);

    ctrl_pkg::pu_signals_t io_signals;
    ctrl_pkg::pu_signals_t mult_signals;
    ctrl_pkg::pu_signals_t accum_signals;
    bus_pkg::bus_word_t    bus;
    bus_pkg::bus_word_t    io_bus;
    bus_pkg::bus_word_t    mult_bus;
    bus_pkg::bus_word_t    accum_bus;
    logic                  stall;

    // Idle units drive zero.
    assign bus = io_bus | mult_bus | accum_bus;

    control_unit u_control (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .io_signals(io_signals),
        .mult_signals(mult_signals),
        .accum_signals(accum_signals)
    );

    pu_io u_io (
        .clk(clk),
        .rst(rst),
        .signals(io_signals),
        .bus_in(bus),
        .bus_out(io_bus),
        .in_word(in_word),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_word(out_word),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .stall(stall)
    );

    pu_multiplier u_mult (
        .clk(clk),
        .rst(rst),
        .signals(mult_signals),
        .bus_in(bus),
        .bus_out(mult_bus)
    );

    pu_accum u_accum (
        .clk(clk),
        .rst(rst),
        .signals(accum_signals),
        .bus_in(bus),
        .bus_out(accum_bus)
    );

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`default_nettype none

module control_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    output ctrl_pkg::pu_signals_t io_signals,
    output ctrl_pkg::pu_signals_t mult_signals,
    output ctrl_pkg::pu_signals_t accum_signals
);

`include "microcode_program.svh"

    logic [ctrl_pkg::STEP_WIDTH-1:0] step;  // Next word to present.
    ctrl_pkg::micro_word_t           word_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
            word_q <= '0;  // Idle word.
        end else if (!stall) begin
            word_q <= MICROCODE[step];
            if (MICROCODE[step].last) begin
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // Stall comes from io's own signals, so io gates its wr internally.
    assign io_signals = word_q.io;

    always_comb begin
        mult_signals = word_q.mult;
        mult_signals.wr = word_q.mult.wr & ~stall;
        accum_signals = word_q.accum;
        accum_signals.wr = word_q.accum.wr & ~stall;
    end

endmodule

`default_nettype wire

/* verilog/pu_io.sv */
`default_nettype none

module pu_io (
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::pu_signals_t signals,
    input  bus_pkg::bus_word_t    bus_in,
    output bus_pkg::bus_word_t    bus_out,
    input  bus_pkg::bus_word_t    in_word,
    input  logic                  in_valid,
    output logic                  in_ready,
    output bus_pkg::bus_word_t    out_word,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  stall
);

    bus_pkg::bus_word_t                          in_mem [bus_pkg::IO_IN_DEPTH];
    logic [$clog2(bus_pkg::IO_IN_DEPTH)-1:0]     in_wr_ptr;
    logic [$clog2(bus_pkg::IO_IN_DEPTH)-1:0]     in_rd_ptr;
    logic [$clog2(bus_pkg::IO_IN_DEPTH+1)-1:0]   in_count;
    bus_pkg::bus_word_t                          out_mem [bus_pkg::IO_OUT_DEPTH];
    logic [$clog2(bus_pkg::IO_OUT_DEPTH)-1:0]    out_wr_ptr;
    logic [$clog2(bus_pkg::IO_OUT_DEPTH)-1:0]    out_rd_ptr;
    logic [$clog2(bus_pkg::IO_OUT_DEPTH+1)-1:0]  out_count;
    logic ready_en;  // Low for the first cycle out of reset.
    logic in_empty;
    logic out_full;
    logic in_push;
    logic in_pop;
    logic out_push;
    logic out_pop;

    assign in_empty = (in_count == 0);
    assign out_full = (out_count == bus_pkg::IO_OUT_DEPTH);

    assign stall = (signals.oe & in_empty) | (signals.wr & out_full);

    assign in_ready = ready_en & (in_count != bus_pkg::IO_IN_DEPTH);
    assign in_push = in_valid & in_ready;
    assign in_pop = signals.oe & ~stall;
    assign out_valid = (out_count != 0);
    assign out_pop = out_valid & out_ready;
    assign out_push = signals.wr & ~stall;  // The control unit leaves io wr ungated.

    assign out_word = out_mem[out_rd_ptr];
    assign bus_out = signals.oe ? in_mem[in_rd_ptr] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_en <= 1'b0;
            in_wr_ptr <= '0;
            in_rd_ptr <= '0;
            in_count <= '0;
            out_wr_ptr <= '0;
            out_rd_ptr <= '0;
            out_count <= '0;
        end else begin
            ready_en <= 1'b1;
            in_wr_ptr <= in_wr_ptr + in_push;
            in_rd_ptr <= in_rd_ptr + in_pop;
            in_count <= in_count + in_push - in_pop;
            out_wr_ptr <= out_wr_ptr + out_push;
            out_rd_ptr <= out_rd_ptr + out_pop;
            out_count <= out_count + out_push - out_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (in_push) begin
            in_mem[in_wr_ptr] <= in_word;
        end
        if (out_push) begin
            out_mem[out_wr_ptr] <= bus_in;
        end
    end

endmodule

`default_nettype wire

/* verilog/pu_accum.sv */
`default_nettype none

module pu_accum (
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::pu_signals_t signals,
    input  bus_pkg::bus_word_t    bus_in,
    output bus_pkg::bus_word_t    bus_out
);

    logic [bus_pkg::DATA_WIDTH-1:0] acc;
    logic                           acc_inv;
    logic                           add_sel;  // Set once the first operand is loaded.
    logic [bus_pkg::DATA_WIDTH-1:0] sum;
    logic                           in_inv;
    logic                           overflow;

    assign in_inv = bus_in.attr[bus_pkg::ATTR_INVALID];
    assign sum = acc + bus_in.data;  // Wraps at 32 bits.

    // Same operand signs, different result sign.
    assign overflow = (acc[bus_pkg::DATA_WIDTH-1] == bus_in.data[bus_pkg::DATA_WIDTH-1])
                   && (sum[bus_pkg::DATA_WIDTH-1] != acc[bus_pkg::DATA_WIDTH-1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            add_sel <= 1'b0;
        end else if (signals.wr) begin
            add_sel <= ~add_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (signals.wr) begin
            if (!add_sel) begin
                acc <= bus_in.data;
                acc_inv <= in_inv;
            end else begin
                acc <= sum;
                acc_inv <= acc_inv | in_inv | overflow;
            end
        end
    end

    always_comb begin
        bus_out = '0;
        if (signals.oe) begin
            bus_out.data = acc;
            bus_out.attr[bus_pkg::ATTR_INVALID] = acc_inv;
        end
    end

endmodule

`default_nettype wire

/* verilog/pu_multiplier.sv */
`default_nettype none

module pu_multiplier (
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::pu_signals_t signals,
    input  bus_pkg::bus_word_t    bus_in,
    output bus_pkg::bus_word_t    bus_out
);

    logic [bus_pkg::DATA_WIDTH-1:0]        arg [2];
    logic                                  arg_inv [2];
    logic                                  arg_sel;  // Which argument the next write fills.
    logic                                  load_d;   // Second argument landed last cycle.
    logic                                  prod_vld;
    logic signed [bus_pkg::DATA_WIDTH-1:0] product;
    logic signed [bus_pkg::DATA_WIDTH-1:0] prod_q;
    logic                                  prod_inv;
    logic [bus_pkg::DATA_WIDTH-1:0]        res_data;
    logic                                  res_inv;

    // True when the upper half only repeats the sign of the low half.
    function automatic logic in_range(input logic [bus_pkg::DATA_WIDTH-1:0] v);
        logic [bus_pkg::DATA_WIDTH-bus_pkg::HALF_WIDTH:0] top;
        top = v[bus_pkg::DATA_WIDTH-1:bus_pkg::HALF_WIDTH-1];
        return (&top) | ~(|top);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            arg_sel <= 1'b0;
        end else if (signals.wr) begin
            arg_sel <= ~arg_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (signals.wr) begin
            arg[arg_sel] <= bus_in.data;
            arg_inv[arg_sel] <= bus_in.attr[bus_pkg::ATTR_INVALID];
        end
    end

    assign product = $signed(arg[0][bus_pkg::HALF_WIDTH-1:0])
                   * $signed(arg[1][bus_pkg::HALF_WIDTH-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_d <= 1'b0;
            prod_vld <= 1'b0;
        end else begin
            load_d <= signals.wr & arg_sel;
            prod_vld <= load_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load_d) begin
            prod_q <= product;
            prod_inv <= arg_inv[0] | arg_inv[1] | ~in_range(arg[0]) | ~in_range(arg[1]);
        end
        if (prod_vld) begin
            res_data <= prod_q >>> bus_pkg::SCALE_POWER;  // Rounds toward minus infinity.
            res_inv <= prod_inv;
        end
    end

    always_comb begin
        bus_out = '0;
        if (signals.oe) begin
            bus_out.data = res_data;
            bus_out.attr[bus_pkg::ATTR_INVALID] = res_inv;
        end
    end

endmodule

`default_nettype wire

/* verilog/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    localparam int PROGRAM_LENGTH = 8;
    localparam int STEP_WIDTH     = $clog2(PROGRAM_LENGTH);

    // Control pair for one processing unit.
    typedef struct packed {
        logic wr;  // Capture the bus this cycle.
        logic oe;  // Drive the bus this cycle.
    } pu_signals_t;

    // One microprogram step.
    typedef struct packed {
        pu_signals_t io;
        pu_signals_t mult;
        pu_signals_t accum;
        logic        last;  // Wrap to step 0 after this word.
    } micro_word_t;

endpackage

`default_nettype wire

/* verilog/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int HALF_WIDTH = DATA_WIDTH / 2;  // Multiplier operand width.
    localparam int ATTR_WIDTH = 4;

    // Bit index of the invalid flag within attr.
    localparam int ATTR_INVALID = 0;

    // Right shift applied to the product, fixed point.
    localparam int SCALE_POWER = 4;

    // Host stream buffering in the I/O unit.
    localparam int IO_IN_DEPTH  = 4;
    localparam int IO_OUT_DEPTH = 2;

    // One word on the shared bus and on the host streams.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [ATTR_WIDTH-1:0] attr;
    } bus_word_t;

endpackage

`default_nettype wire

/* include/microcode_program.svh */
`ifndef MICROCODE_PROGRAM_SVH
`define MICROCODE_PROGRAM_SVH

localparam ctrl_pkg::pu_signals_t SIG_NONE = '{wr: 1'b0, oe: 1'b0};
localparam ctrl_pkg::pu_signals_t SIG_WR   = '{wr: 1'b1, oe: 1'b0};
localparam ctrl_pkg::pu_signals_t SIG_OE   = '{wr: 1'b0, oe: 1'b1};

// y = ((a * b) >>> SCALE_POWER) + c, one triple per pass.
localparam ctrl_pkg::micro_word_t MICROCODE [ctrl_pkg::PROGRAM_LENGTH] = '{
    // a into the multiplier.
    '{io: SIG_OE, mult: SIG_WR, accum: SIG_NONE, last: 1'b0},
    // b into the multiplier.
    '{io: SIG_OE, mult: SIG_WR, accum: SIG_NONE, last: 1'b0},
    // c loads the accumulator.
    '{io: SIG_OE, mult: SIG_NONE, accum: SIG_WR, last: 1'b0},
    // Product still in flight.
    '{io: SIG_NONE, mult: SIG_NONE, accum: SIG_NONE, last: 1'b0},
    // Scaled product added to c.
    '{io: SIG_NONE, mult: SIG_OE, accum: SIG_WR, last: 1'b0},
    '{io: SIG_NONE, mult: SIG_NONE, accum: SIG_NONE, last: 1'b0},
    // Sum out to the host.
    '{io: SIG_WR, mult: SIG_NONE, accum: SIG_OE, last: 1'b0},
    '{io: SIG_NONE, mult: SIG_NONE, accum: SIG_NONE, last: 1'b1}
};

`endif
